// ==== source/pmu_pkg.sv ====
// Performance monitor package
// Widths, register map, event selects and the packed bus and event
// structs shared by the probe, the counter bank and the config block
package pmu_pkg;

  // Memory path
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Config port
  localparam int unsigned CFG_AW = 8;
  localparam int unsigned CFG_DW = 32;

  // Counter bank
  localparam int unsigned NUM_COUNTER = 8;
  localparam int unsigned CNT_W       = 32;
  localparam int unsigned CNT_IDX_W   = $clog2(NUM_COUNTER);

  // Probe timestamps and in-flight tracking
  localparam int unsigned TS_W         = 16;
  localparam int unsigned PROBE_DEPTH  = 4;
  localparam int unsigned PROBE_PTR_W  = $clog2(PROBE_DEPTH);
  localparam int unsigned PROBE_FILL_W = $clog2(PROBE_DEPTH + 1);

  // Register map, word stride, each array base aligned to its span
  localparam logic [CFG_AW-1:0] REG_CNT_BASE   = 8'h00;
  localparam logic [CFG_AW-1:0] REG_SEL_BASE   = 8'h20;
  localparam logic [CFG_AW-1:0] REG_THR_BASE   = 8'h40;
  localparam logic [CFG_AW-1:0] REG_IRQ        = 8'h60;
  localparam logic [CFG_AW-1:0] REG_ARRAY_SPAN = CFG_AW'(NUM_COUNTER * 4);

  // Returned for reads that hit no register
  localparam logic [CFG_DW-1:0] UNMAPPED_RDATA = 32'hdeadf000;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  typedef enum logic [2:0] {
    EVT_OFF,
    EVT_RD_COUNT,
    EVT_WR_COUNT,
    EVT_RD_LAT,
    EVT_WR_LAT
  } evt_sel_e;

  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    logic [DATA_W-1:0] rdata;
  } mem_resp_t;

  // One completed transaction as seen by the probe
  typedef struct packed {
    logic            valid;
    mem_op_e         op;
    logic [TS_W-1:0] latency;
  } mem_event_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [CFG_AW-1:0] addr;
    logic [CFG_DW-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              valid;
    logic [CFG_DW-1:0] rdata;
  } cfg_resp_t;

  // Counter load order from the config block
  typedef struct packed {
    logic                 valid;
    logic [CNT_IDX_W-1:0] index;
    logic [CNT_W-1:0]     value;
  } cnt_write_t;

  typedef evt_sel_e [NUM_COUNTER-1:0]        sel_vec_t;
  typedef logic [NUM_COUNTER-1:0][CNT_W-1:0] cnt_vec_t;
  typedef logic [NUM_COUNTER-1:0][CNT_W-1:0] thr_vec_t;

endpackage

// ==== source/traffic_probe.sv ====
// Traffic probe
// Passes the memory request and response paths through unchanged and
// timestamps every accepted request in an in-flight FIFO. Each response
// handshake pops the oldest stamp and emits a registered latency event.
// Requests stall once PROBE_DEPTH transactions are outstanding.
`timescale 1ns/1ps

module traffic_probe (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  pmu_pkg::mem_req_t   cpu_req_i,
  output logic                cpu_req_ready_o,
  output pmu_pkg::mem_resp_t  cpu_resp_o,
  input  logic                cpu_resp_ready_i,
  output pmu_pkg::mem_req_t   mem_req_o,
  input  logic                mem_req_ready_i,
  input  pmu_pkg::mem_resp_t  mem_resp_i,
  output logic                mem_resp_ready_o,
  output pmu_pkg::mem_event_t event_o
);
  import pmu_pkg::*;

  logic [TS_W-1:0]         ts_q;
  logic [TS_W-1:0]         fifo_ts [PROBE_DEPTH];
  mem_op_e                 fifo_op [PROBE_DEPTH];
  logic [PROBE_PTR_W-1:0]  wr_ptr_q;
  logic [PROBE_PTR_W-1:0]  rd_ptr_q;
  logic [PROBE_FILL_W-1:0] fill_q;
  logic                    fifo_full;
  logic                    fifo_empty;
  logic                    push;
  logic                    pop;
  logic                    evt_valid_q;
  mem_op_e                 evt_op_q;
  logic [TS_W-1:0]         evt_lat_q;

  function automatic logic [PROBE_PTR_W-1:0] ptr_next(logic [PROBE_PTR_W-1:0] ptr);
    if (ptr == PROBE_PTR_W'(PROBE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign fifo_full  = (fill_q == PROBE_FILL_W'(PROBE_DEPTH));
  assign fifo_empty = (fill_q == '0);

  // Request path, only valid and ready are held back when full
  assign mem_req_o.valid = cpu_req_i.valid && !fifo_full;
  assign mem_req_o.op    = cpu_req_i.op;
  assign mem_req_o.addr  = cpu_req_i.addr;
  assign mem_req_o.wdata = cpu_req_i.wdata;
  assign cpu_req_ready_o = mem_req_ready_i && !fifo_full;

  // Response path passes straight through
  assign cpu_resp_o       = mem_resp_i;
  assign mem_resp_ready_o = cpu_resp_ready_i;

  assign push = cpu_req_i.valid && cpu_req_ready_o;
  assign pop  = mem_resp_i.valid && cpu_resp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ts_q        <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      fill_q      <= '0;
      evt_valid_q <= 1'b0;
    end else begin
      ts_q        <= ts_q + 1'b1;
      fill_q      <= fill_q + PROBE_FILL_W'(push) - PROBE_FILL_W'(pop);
      evt_valid_q <= pop;
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
    end
  end

  // Stamp taken in the request handshake cycle
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_ts[wr_ptr_q] <= ts_q;
      fifo_op[wr_ptr_q] <= cpu_req_i.op;
    end
  end

  // Wraps safely as long as latency stays below 2**TS_W cycles
  always_ff @(posedge clk_i) begin
    if (pop) begin
      evt_op_q  <= fifo_op[rd_ptr_q];
      evt_lat_q <= ts_q - fifo_ts[rd_ptr_q];
    end
  end

  assign event_o.valid   = evt_valid_q;
  assign event_o.op      = evt_op_q;
  assign event_o.latency = evt_lat_q;

  // The in-flight count never overruns the FIFO
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    fill_q <= PROBE_FILL_W'(PROBE_DEPTH)
  );

  // Memory side only answers requests it has actually received
  a_no_resp_when_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pop |-> !fifo_empty
  );

endmodule

// ==== source/event_counter_bank.sv ====
// Event counter bank
// Eight counters, each counting or summing the latency of the read or
// write events chosen by its select. A sticky interrupt bit sets once a
// counter reaches its nonzero threshold and clears when it is written.
`timescale 1ns/1ps

module event_counter_bank (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  pmu_pkg::mem_event_t         event_i,
  input  pmu_pkg::sel_vec_t           sel_i,
  input  pmu_pkg::thr_vec_t           thr_i,
  input  pmu_pkg::cnt_write_t         cnt_wr_i,
  output pmu_pkg::cnt_vec_t           counts_o,
  output logic [pmu_pkg::NUM_COUNTER-1:0] irq_o
);
  import pmu_pkg::*;

  cnt_vec_t               cnt_q;
  cnt_vec_t               cnt_d;
  cnt_vec_t               add;
  logic [NUM_COUNTER-1:0] irq_q;
  logic [NUM_COUNTER-1:0] irq_d;
  logic [NUM_COUNTER-1:0] wr_hit;
  logic                   is_rd;
  logic                   is_wr;
  logic [CNT_W-1:0]       lat_ext;

  assign is_rd   = event_i.valid && (event_i.op == MEM_READ);
  assign is_wr   = event_i.valid && (event_i.op == MEM_WRITE);
  assign lat_ext = CNT_W'(event_i.latency);

  always_comb begin
    for (int i = 0; i < NUM_COUNTER; i++) begin
      unique case (sel_i[i])
        EVT_RD_COUNT: add[i] = is_rd ? CNT_W'(1) : '0;
        EVT_WR_COUNT: add[i] = is_wr ? CNT_W'(1) : '0;
        EVT_RD_LAT:   add[i] = is_rd ? lat_ext : '0;
        EVT_WR_LAT:   add[i] = is_wr ? lat_ext : '0;
        default:      add[i] = '0;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_COUNTER; i++) begin
      wr_hit[i] = cnt_wr_i.valid && (cnt_wr_i.index == CNT_IDX_W'(i));
      // A load wins over a same-cycle event
      if (wr_hit[i]) begin
        cnt_d[i] = cnt_wr_i.value;
        irq_d[i] = 1'b0;
      end else begin
        cnt_d[i] = cnt_q[i] + add[i];
        irq_d[i] = irq_q[i] || ((thr_i[i] != '0) && (cnt_q[i] >= thr_i[i]));
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      irq_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      irq_q <= irq_d;
    end
  end

  assign counts_o = cnt_q;
  assign irq_o    = irq_q;

endmodule

// ==== source/pmu_cfg_regs.sv ====
// Monitor configuration registers
// Single request and response channel with valid/ready, one transaction
// outstanding. Holds the event selects and thresholds, turns counter
// writes into load orders and reads back counters and interrupt status.
`timescale 1ns/1ps

module pmu_cfg_regs (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  pmu_pkg::cfg_req_t               cfg_req_i,
  output logic                            cfg_req_ready_o,
  output pmu_pkg::cfg_resp_t              cfg_resp_o,
  input  logic                            cfg_resp_ready_i,
  input  pmu_pkg::cnt_vec_t               counts_i,
  input  logic [pmu_pkg::NUM_COUNTER-1:0] irq_i,
  output pmu_pkg::sel_vec_t               sel_o,
  output pmu_pkg::thr_vec_t               thr_o,
  output pmu_pkg::cnt_write_t             cnt_wr_o
);
  import pmu_pkg::*;

  logic                 resp_valid_q;
  logic [CFG_DW-1:0]    rdata_q;
  logic [CFG_DW-1:0]    rdata_d;
  logic                 req_hs;
  logic                 hit_cnt;
  logic                 hit_sel;
  logic                 hit_thr;
  logic                 hit_irq;
  logic [CNT_IDX_W-1:0] req_idx;
  evt_sel_e             wr_sel;
  sel_vec_t             sel_q;
  thr_vec_t             thr_q;

  function automatic logic in_array(logic [CFG_AW-1:0] addr, logic [CFG_AW-1:0] base);
    return (addr >= base) && (addr < base + REG_ARRAY_SPAN) && (addr[1:0] == 2'b00);
  endfunction

  assign cfg_req_ready_o = !resp_valid_q;
  assign req_hs          = cfg_req_i.valid && cfg_req_ready_o;

  assign hit_cnt = in_array(cfg_req_i.addr, REG_CNT_BASE);
  assign hit_sel = in_array(cfg_req_i.addr, REG_SEL_BASE);
  assign hit_thr = in_array(cfg_req_i.addr, REG_THR_BASE);
  assign hit_irq = (cfg_req_i.addr == REG_IRQ);
  // Bases are span aligned so the word offset is the index
  assign req_idx = cfg_req_i.addr[CNT_IDX_W+1:2];

  // Unknown select codes fall back to off
  always_comb begin
    case (cfg_req_i.wdata[2:0])
      3'd1:    wr_sel = EVT_RD_COUNT;
      3'd2:    wr_sel = EVT_WR_COUNT;
      3'd3:    wr_sel = EVT_RD_LAT;
      3'd4:    wr_sel = EVT_WR_LAT;
      default: wr_sel = EVT_OFF;
    endcase
  end

  always_comb begin
    rdata_d = UNMAPPED_RDATA;
    if (cfg_req_i.write) begin
      rdata_d = '0;
    end else if (hit_cnt) begin
      rdata_d = counts_i[req_idx];
    end else if (hit_sel) begin
      rdata_d = CFG_DW'(sel_q[req_idx]);
    end else if (hit_thr) begin
      rdata_d = thr_q[req_idx];
    end else if (hit_irq) begin
      rdata_d = CFG_DW'(irq_i);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
      thr_q        <= '0;
      for (int i = 0; i < NUM_COUNTER; i++) begin
        sel_q[i] <= EVT_OFF;
      end
    end else begin
      if (req_hs) begin
        resp_valid_q <= 1'b1;
      end else if (cfg_resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
      if (req_hs && cfg_req_i.write && hit_sel) begin
        sel_q[req_idx] <= wr_sel;
      end
      if (req_hs && cfg_req_i.write && hit_thr) begin
        thr_q[req_idx] <= cfg_req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      rdata_q <= rdata_d;
    end
  end

  // Counter loads land in the bank at the handshake edge
  assign cnt_wr_o.valid = req_hs && cfg_req_i.write && hit_cnt;
  assign cnt_wr_o.index = req_idx;
  assign cnt_wr_o.value = cfg_req_i.wdata;

  assign cfg_resp_o.valid = resp_valid_q;
  assign cfg_resp_o.rdata = rdata_q;
  assign sel_o            = sel_q;
  assign thr_o            = thr_q;

  // Every response follows an accepted request one cycle earlier
  a_resp_after_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $rose(resp_valid_q) |-> $past(req_hs)
  );

endmodule

// ==== source/host_perf_domain.sv ====
// Host performance monitor top level
// Memory path through the traffic probe, whose latency events feed the
// counter bank, configured and read back over the register port
`timescale 1ns/1ps

module host_perf_domain (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  pmu_pkg::mem_req_t               cpu_req_i,
  output logic                            cpu_req_ready_o,
  output pmu_pkg::mem_resp_t              cpu_resp_o,
  input  logic                            cpu_resp_ready_i,
  output pmu_pkg::mem_req_t               mem_req_o,
  input  logic                            mem_req_ready_i,
  input  pmu_pkg::mem_resp_t              mem_resp_i,
  output logic                            mem_resp_ready_o,
  input  pmu_pkg::cfg_req_t               cfg_req_i,
  output logic                            cfg_req_ready_o,
  output pmu_pkg::cfg_resp_t              cfg_resp_o,
  input  logic                            cfg_resp_ready_i,
  output logic [pmu_pkg::NUM_COUNTER-1:0] irq_o
);
  import pmu_pkg::*;

  mem_event_t             probe_event;
  sel_vec_t               cnt_sel;
  thr_vec_t               cnt_thr;
  cnt_write_t             cnt_wr;
  cnt_vec_t               cnt_value;
  logic [NUM_COUNTER-1:0] cnt_irq;

  traffic_probe traffic_probe_inst (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .cpu_req_i        ( cpu_req_i        ),
    .cpu_req_ready_o  ( cpu_req_ready_o  ),
    .cpu_resp_o       ( cpu_resp_o       ),
    .cpu_resp_ready_i ( cpu_resp_ready_i ),
    .mem_req_o        ( mem_req_o        ),
    .mem_req_ready_i  ( mem_req_ready_i  ),
    .mem_resp_i       ( mem_resp_i       ),
    .mem_resp_ready_o ( mem_resp_ready_o ),
    .event_o          ( probe_event      )
  );

  event_counter_bank event_counter_bank_inst (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .event_i  ( probe_event ),
    .sel_i    ( cnt_sel     ),
    .thr_i    ( cnt_thr     ),
    .cnt_wr_i ( cnt_wr      ),
    .counts_o ( cnt_value   ),
    .irq_o    ( cnt_irq     )
  );

  pmu_cfg_regs pmu_cfg_regs_inst (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .cfg_req_i        ( cfg_req_i        ),
    .cfg_req_ready_o  ( cfg_req_ready_o  ),
    .cfg_resp_o       ( cfg_resp_o       ),
    .cfg_resp_ready_i ( cfg_resp_ready_i ),
    .counts_i         ( cnt_value        ),
    .irq_i            ( cnt_irq          ),
    .sel_o            ( cnt_sel          ),
    .thr_o            ( cnt_thr          ),
    .cnt_wr_o         ( cnt_wr           )
  );

  assign irq_o = cnt_irq;

endmodule

// ==== sim/tb_mem_responder.sv ====
// Memory model for the monitor testbench
// Accepts every request, stores write data and answers in request order
// a programmable number of cycles after each handshake. Reads return the
// stored word, or the address itself for a word never written.
`timescale 1ns/1ps

module tb_mem_responder (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  pmu_pkg::mem_req_t  mem_req_i,
  output logic               mem_req_ready_o,
  output pmu_pkg::mem_resp_t mem_resp_o,
  input  logic               mem_resp_ready_i,
  input  int unsigned        delay_i,
  input  logic               hold_i
);
  import pmu_pkg::*;

  logic [DATA_W-1:0] store [logic [ADDR_W-1:0]];
  mem_resp_t         pend_q [$];
  longint unsigned   due_q [$];
  longint unsigned   cycle;

  initial begin
    mem_req_ready_o = 1'b0;
    mem_resp_o      = '0;
    cycle           = 0;
  end

  // Bookkeeping at the clock edge where handshakes complete
  always @(posedge clk_i or negedge arst_n_i) begin : track
    mem_resp_t resp;
    if (!arst_n_i) begin
      pend_q.delete();
      due_q.delete();
      cycle = 0;
    end else begin
      cycle = cycle + 1;
      if (mem_resp_o.valid && mem_resp_ready_i) begin
        void'(pend_q.pop_front());
        void'(due_q.pop_front());
      end
      if (mem_req_i.valid && mem_req_ready_o) begin
        resp.valid = 1'b1;
        resp.op    = mem_req_i.op;
        resp.rdata = '0;
        if (mem_req_i.op == MEM_WRITE) begin
          store[mem_req_i.addr] = mem_req_i.wdata;
        end else if (store.exists(mem_req_i.addr)) begin
          resp.rdata = store[mem_req_i.addr];
        end else begin
          resp.rdata = mem_req_i.addr;
        end
        pend_q.push_back(resp);
        due_q.push_back(cycle + delay_i);
      end
    end
  end

  // Head is offered in the cycle that ends on its due edge
  always @(negedge clk_i) begin
    mem_req_ready_o = arst_n_i;
    if (arst_n_i && !hold_i && (pend_q.size() > 0) && (due_q[0] <= cycle + 1)) begin
      mem_resp_o = pend_q[0];
    end else begin
      mem_resp_o = '0;
    end
  end

endmodule

// ==== sim/tb_host_perf_domain.sv ====
// Testbench for the host performance monitor
// Directed tests over the config port and the memory path, with an
// in-order response scoreboard, an LCG for addresses and data, and a
// watchdog sized from the per-test cycle bounds
`timescale 1ns/1ps

module tb_host_perf_domain;
  import pmu_pkg::*;

  localparam int unsigned CLK_PERIOD  = 10;
  localparam int unsigned RST_CYCLES  = 10;
  localparam int unsigned WAIT_LIMIT  = 200;
  localparam logic [CFG_DW-1:0] PLACEHOLDER_WORD = 32'hdeadf000;

  // Cycle bounds for each test
  localparam int unsigned T1_CYCLES = 300;
  localparam int unsigned T2_CYCLES = 300;
  localparam int unsigned T3_CYCLES = 600;
  localparam int unsigned T4_CYCLES = 500;
  localparam int unsigned T5_CYCLES = 500;
  localparam int unsigned T6_CYCLES = 500;
  localparam int unsigned WATCHDOG_CYCLES = RST_CYCLES + T1_CYCLES + T2_CYCLES +
                                            T3_CYCLES + T4_CYCLES + T5_CYCLES + T6_CYCLES;

  logic                   clk;
  logic                   arst_n;
  mem_req_t               cpu_req;
  logic                   cpu_req_ready;
  mem_resp_t              cpu_resp;
  logic                   cpu_resp_ready;
  mem_req_t               mem_req;
  logic                   mem_req_ready;
  mem_resp_t              mem_resp;
  logic                   mem_resp_ready;
  cfg_req_t               cfg_req;
  logic                   cfg_req_ready;
  cfg_resp_t              cfg_resp;
  logic                   cfg_resp_ready;
  logic [NUM_COUNTER-1:0] irq;
  int unsigned            resp_delay;
  logic                   resp_hold;

  // Scoreboard state
  mem_resp_t         exp_q [$];
  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  int unsigned       req_count;
  logic [31:0]       lcg_state = 32'h11c31aa5;

  host_perf_domain host_perf_domain_inst (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .cpu_req_i        ( cpu_req        ),
    .cpu_req_ready_o  ( cpu_req_ready  ),
    .cpu_resp_o       ( cpu_resp       ),
    .cpu_resp_ready_i ( cpu_resp_ready ),
    .mem_req_o        ( mem_req        ),
    .mem_req_ready_i  ( mem_req_ready  ),
    .mem_resp_i       ( mem_resp       ),
    .mem_resp_ready_o ( mem_resp_ready ),
    .cfg_req_i        ( cfg_req        ),
    .cfg_req_ready_o  ( cfg_req_ready  ),
    .cfg_resp_o       ( cfg_resp       ),
    .cfg_resp_ready_i ( cfg_resp_ready ),
    .irq_o            ( irq            )
  );

  tb_mem_responder tb_mem_responder_inst (
    .clk_i            ( clk            ),
    .arst_n_i         ( arst_n         ),
    .mem_req_i        ( mem_req        ),
    .mem_req_ready_o  ( mem_req_ready  ),
    .mem_resp_o       ( mem_resp       ),
    .mem_resp_ready_i ( mem_resp_ready ),
    .delay_i          ( resp_delay     ),
    .hold_i           ( resp_hold      )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [CFG_AW-1:0] reg_addr(logic [CFG_AW-1:0] base, int unsigned idx);
    return base + CFG_AW'(idx * 4);
  endfunction

  task automatic fail_run();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mem_rdata(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mem_op(input string name, input mem_op_e got, input mem_op_e exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_cfg_rdata(input string name, input logic [CFG_DW-1:0] got,
                                 input logic [CFG_DW-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_irq(input string name, input logic [NUM_COUNTER-1:0] got,
                           input logic [NUM_COUNTER-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  // Scoreboard on the CPU side that matches responses to requests in order
  always @(posedge clk) begin : mem_monitor
    mem_resp_t exp_resp;
    mem_req_t  exp_req;
    if (arst_n) begin
      // The request passes through and is held back only with PROBE_DEPTH in flight
      exp_req       = cpu_req;
      exp_req.valid = cpu_req.valid && (exp_q.size() < PROBE_DEPTH);
      check_mem_req("mem_req_o", mem_req, exp_req);
      if (cpu_resp.valid && cpu_resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error: memory response arrived with no request outstanding");
          fail_run();
        end
        exp_resp = exp_q.pop_front();
        check_mem_op("cpu_resp.op", cpu_resp.op, exp_resp.op);
        if (exp_resp.op == MEM_READ) begin
          check_mem_rdata("cpu_resp.rdata", cpu_resp.rdata, exp_resp.rdata);
        end
      end
      if (cpu_req.valid && cpu_req_ready) begin
        exp_resp.valid = 1'b1;
        exp_resp.op    = cpu_req.op;
        exp_resp.rdata = cpu_req.addr;
        if (cpu_req.op == MEM_WRITE) begin
          shadow[cpu_req.addr] = cpu_req.wdata;
        end else if (shadow.exists(cpu_req.addr)) begin
          exp_resp.rdata = shadow[cpu_req.addr];
        end
        exp_q.push_back(exp_resp);
        req_count++;
      end
    end
  end

  task automatic cfg_access(input logic write, input logic [CFG_AW-1:0] addr,
                            input logic [CFG_DW-1:0] wdata, output logic [CFG_DW-1:0] rdata);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    cfg_req.valid = 1'b1;
    cfg_req.write = write;
    cfg_req.addr  = addr;
    cfg_req.wdata = wdata;
    @(posedge clk);
    while (!cfg_req_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Error: config request at 0x%h was never accepted", addr);
        fail_run();
      end
      @(posedge clk);
    end
    @(negedge clk);
    cfg_req.valid = 1'b0;
    // Response is due in the cycle after the handshake
    if (!cfg_resp.valid) begin
      $display("Error: no config response in the cycle after request 0x%h", addr);
      fail_run();
    end
    rdata = cfg_resp.rdata;
  endtask

  task automatic cfg_write(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] wdata);
    logic [CFG_DW-1:0] unused;
    cfg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic cfg_expect(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] exp);
    logic [CFG_DW-1:0] rdata;
    cfg_access(1'b0, addr, '0, rdata);
    check_cfg_rdata($sformatf("cfg_rdata[0x%h]", addr), rdata, exp);
  endtask

  task automatic issue_mem(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    cpu_req.valid = 1'b1;
    cpu_req.op    = op;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    @(posedge clk);
    while (!cpu_req_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Error: memory request to 0x%h was never accepted", addr);
        fail_run();
      end
      @(posedge clk);
    end
    @(negedge clk);
    cpu_req.valid = 1'b0;
  endtask

  // Waits for every response, then for the event and counter update
  task automatic drain_mem();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Error: %0d memory responses did not complete", exp_q.size());
        fail_run();
      end
      @(negedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic clear_monitor();
    for (int i = 0; i < NUM_COUNTER; i++) begin
      cfg_write(reg_addr(REG_SEL_BASE, i), CFG_DW'(EVT_OFF));
      cfg_write(reg_addr(REG_THR_BASE, i), '0);
      cfg_write(reg_addr(REG_CNT_BASE, i), '0);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_irq("irq_o", irq, '0);
    for (int i = 0; i < NUM_COUNTER; i++) begin
      cfg_expect(reg_addr(REG_CNT_BASE, i), '0);
      cfg_expect(reg_addr(REG_SEL_BASE, i), '0);
      cfg_expect(reg_addr(REG_THR_BASE, i), '0);
    end
    cfg_expect(REG_IRQ, '0);
    cfg_expect(8'h70, PLACEHOLDER_WORD);
    cfg_expect(8'hfc, PLACEHOLDER_WORD);
  endtask

  task automatic test_register_access();
    logic [2:0]        codes [NUM_COUNTER];
    logic [CFG_DW-1:0] thrs [NUM_COUNTER];
    logic [CFG_DW-1:0] cnt_val;
    for (int i = 0; i < NUM_COUNTER; i++) begin
      codes[i] = 3'(lcg_next() % 5);
      thrs[i]  = lcg_next();
      cfg_write(reg_addr(REG_SEL_BASE, i), CFG_DW'(codes[i]));
      cfg_write(reg_addr(REG_THR_BASE, i), thrs[i]);
    end
    for (int i = 0; i < NUM_COUNTER; i++) begin
      cfg_expect(reg_addr(REG_SEL_BASE, i), CFG_DW'(codes[i]));
      cfg_expect(reg_addr(REG_THR_BASE, i), thrs[i]);
    end
    cnt_val = lcg_next();
    cfg_write(reg_addr(REG_CNT_BASE, 5), cnt_val);
    cfg_expect(reg_addr(REG_CNT_BASE, 5), cnt_val);
  endtask

  task automatic test_pass_through();
    int unsigned n_rd;
    int unsigned n_wr;
    logic [31:0] r;
    n_rd = 0;
    n_wr = 0;
    clear_monitor();
    cfg_write(reg_addr(REG_SEL_BASE, 0), CFG_DW'(EVT_RD_COUNT));
    cfg_write(reg_addr(REG_SEL_BASE, 1), CFG_DW'(EVT_WR_COUNT));
    resp_delay = 6;
    // Small address pool so reads often hit earlier writes
    for (int i = 0; i < 24; i++) begin
      r = lcg_next();
      if (r[16]) begin
        issue_mem(MEM_WRITE, 32'h8000_0000 | (r & 32'h3c), lcg_next());
        n_wr++;
      end else begin
        issue_mem(MEM_READ, 32'h8000_0000 | (r & 32'h3c), '0);
        n_rd++;
      end
    end
    drain_mem();
    cfg_expect(reg_addr(REG_CNT_BASE, 0), CFG_DW'(n_rd));
    cfg_expect(reg_addr(REG_CNT_BASE, 1), CFG_DW'(n_wr));
  endtask

  task automatic test_latency_sum();
    int unsigned delay;
    int unsigned n_rd;
    int unsigned n_wr;
    delay = 5;
    n_rd  = 4;
    n_wr  = 3;
    clear_monitor();
    cfg_write(reg_addr(REG_SEL_BASE, 2), CFG_DW'(EVT_RD_LAT));
    cfg_write(reg_addr(REG_SEL_BASE, 3), CFG_DW'(EVT_WR_LAT));
    resp_delay = delay;
    for (int i = 0; i < n_rd; i++) begin
      issue_mem(MEM_READ, lcg_next() & 32'hffff_fffc, '0);
    end
    for (int i = 0; i < n_wr; i++) begin
      issue_mem(MEM_WRITE, lcg_next() & 32'hffff_fffc, lcg_next());
    end
    drain_mem();
    cfg_expect(reg_addr(REG_CNT_BASE, 2), CFG_DW'(n_rd * delay));
    cfg_expect(reg_addr(REG_CNT_BASE, 3), CFG_DW'(n_wr * delay));
  endtask

  task automatic test_threshold_irq();
    int unsigned            thr;
    int unsigned            idx;
    logic [NUM_COUNTER-1:0] mask;
    thr  = 3;
    idx  = 4;
    mask = NUM_COUNTER'(1) << idx;
    clear_monitor();
    cfg_write(reg_addr(REG_SEL_BASE, idx), CFG_DW'(EVT_RD_COUNT));
    cfg_write(reg_addr(REG_THR_BASE, idx), CFG_DW'(thr));
    resp_delay = 2;
    for (int i = 0; i < thr - 1; i++) begin
      issue_mem(MEM_READ, lcg_next() & 32'hffff_fffc, '0);
    end
    drain_mem();
    @(negedge clk);
    check_irq("irq_o", irq, '0);
    cfg_expect(REG_IRQ, '0);
    issue_mem(MEM_READ, lcg_next() & 32'hffff_fffc, '0);
    drain_mem();
    @(negedge clk);
    check_irq("irq_o", irq, mask);
    cfg_expect(REG_IRQ, CFG_DW'(mask));
    // Loading the counter clears its sticky bit
    cfg_write(reg_addr(REG_CNT_BASE, idx), '0);
    cfg_expect(REG_IRQ, '0);
    @(negedge clk);
    check_irq("irq_o", irq, '0);
  endtask

  task automatic test_back_pressure();
    int unsigned       base;
    logic [ADDR_W-1:0] addrs [3];
    for (int i = 0; i < 3; i++) begin
      addrs[i] = 32'h4000_0000 | (lcg_next() & 32'hfc);
    end
    resp_delay = 2;
    @(negedge clk);
    resp_hold = 1'b1;
    base      = req_count;
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          issue_mem(MEM_WRITE, addrs[i], lcg_next());
        end
        for (int i = 0; i < 3; i++) begin
          issue_mem(MEM_READ, addrs[i], '0);
        end
      end
      begin
        repeat (20) @(posedge clk);
        @(negedge clk);
        if (req_count - base != PROBE_DEPTH) begin
          $display("Error: %0d requests accepted while replies were held, expected %0d",
                   req_count - base, PROBE_DEPTH);
          fail_run();
        end
        repeat (10) begin
          @(posedge clk);
          if (cpu_req_ready) begin
            $display("Error: CPU request ready rose while the probe was full");
            fail_run();
          end
        end
        @(negedge clk);
        resp_hold = 1'b0;
      end
    join
    drain_mem();
  endtask

  initial begin
    arst_n         = 1'b0;
    cpu_req        = '0;
    cpu_resp_ready = 1'b0;
    cfg_req        = '0;
    cfg_resp_ready = 1'b1;
    resp_delay     = 2;
    resp_hold      = 1'b0;
    req_count      = 0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n         = 1'b1;
    cpu_resp_ready = 1'b1;
    test_reset_state();
    test_register_access();
    test_pass_through();
    test_latency_sum();
    test_threshold_irq();
    test_back_pressure();
    @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    fail_run();
  end

endmodule

// ==== sources.f ====
source/pmu_pkg.sv
source/traffic_probe.sv
source/event_counter_bank.sv
source/pmu_cfg_regs.sv
source/host_perf_domain.sv
sim/tb_mem_responder.sv
sim/tb_host_perf_domain.sv
